// File: files.f
+incdir+design
+incdir+tb
design/obj_pkg.sv
design/obj_if.sv
design/obj_frame_ram.sv
design/obj_tile_match.sv
design/obj_line_table.sv
design/obj_draw_dispatch.sv
design/obj_tile_draw.sv
design/obj_line_buf.sv
design/obj_top.sv
tb/obj_tb.sv

// File: tb/obj_tb_model.svh
// ######################################################################
// reference model for the sprite line scanner testbench
// tbl_mem must hold the table exactly as written to the DUT
// ROM rows are a hash of the address, roughly a third transparent
// ######################################################################
`ifndef OBJ_TB_MODEL_SVH
`define OBJ_TB_MODEL_SVH

logic [15:0] tbl_mem  [4*`OBJ_ENTRIES];    // copy of the object table
logic [14:0] exp_line [`OBJ_LINE_W];       // expected readout
int          exp_prio [`OBJ_LINE_W];       // index owning each pixel

// graphics ROM row, nibble 15 is a hole
function automatic logic [63:0] rom_row(input logic [19:0] a);
    logic [31:0] h1;
    logic [31:0] h2;
    logic [63:0] row;
    h1  = {12'd0, a} * 32'h9e37_79b1;
    h1  = h1 ^ (h1 >> 15);
    h2  = (h1 + 32'h7f4a_7c15) * 32'h85eb_ca6b;
    h2  = h2 ^ (h2 >> 13);
    row = {h2, h1};
    for (int i = 0; i < 16; i++) begin
        if (h2[2*i +: 2] == 2'b00) begin
            row[4*i +: 4] = 4'hf;          // extra holes for overlap tests
        end
    end
    return row;
endfunction

// expected line for one vline, lowest index wins on every opaque pixel
task automatic build_expected(input logic [8:0] vline);
    int          x;
    int          d;
    int          tm;
    int          tn;
    int          r;
    int          vs;
    int          np;
    int          px;
    int          xx;
    logic [15:0] attr;
    logic [15:0] cm;
    logic [63:0] row;
    logic [3:0]  nib;
    for (int i = 0; i < `OBJ_LINE_W; i++) begin
        exp_line[i] = '0;
        exp_prio[i] = `OBJ_ENTRIES;        // no owner yet
    end
    for (int idx = 0; idx < `OBJ_ENTRIES; idx++) begin
        x    = tbl_mem[4*idx][8:0];
        d    = (int'(vline) - int'(tbl_mem[4*idx + 1][8:0]) + 512) % 512;
        attr = tbl_mem[4*idx + 3];
        tm   = attr[15:12];
        tn   = attr[11:8];
        if (d < 16 * (tm + 1)) begin
            r  = attr[6] ? tm - d / 16 : d / 16;     // vflip reverses rows
            vs = attr[6] ? 15 - d % 16 : d % 16;
            for (int n = 0; n <= tn; n++) begin
                cm  = tbl_mem[4*idx + 2] + 16'(n) + 16'(16 * r);
                row = rom_row({cm, 4'(vs)});
                np  = attr[5] ? tn - n : n;          // hflip mirrors columns
                for (int c = 0; c < 16; c++) begin
                    px  = attr[5] ? 15 - c : c;
                    nib = row[4*px +: 4];
                    xx  = (x + 16 * np + c) % 512;   // wraps past 511
                    if (nib != 4'hf && idx < exp_prio[xx]) begin
                        exp_prio[xx] = idx;
                        exp_line[xx] = {1'b1, attr[4:0], 5'd0, nib};
                    end
                end
            end
        end
    end
endtask

`endif

// File: tb/obj_tb.sv
// ######################################################################
// testbench for the sprite line scanner, fixed-seed random tables
// graphics ROM is modeled here, data one clock behind gfx_addr
// each test reads the line twice, the second pass must be empty
// ######################################################################
`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_tb;

    localparam int NUM_TESTS      = 9;
    localparam int TEST_CYCLES    = 256 * 8 + 256 * 16 * 16 + 1024;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES;

    logic        clk;
    logic        rst;
    logic        flip;
    logic [8:0]  vrender;
    logic        start;
    logic        tbl_we;
    logic [9:0]  tbl_addr;
    logic [15:0] tbl_wdata;
    logic [19:0] gfx_addr;
    logic [63:0] gfx_data;
    logic        busy;
    logic        rd_en;
    logic [8:0]  rd_addr;
    logic [14:0] rd_data;

    int seed = 32'h80c9_f42d;
    int errors;
    int checks;
    int test_errors;
    int tests_run;
    int cycle_count;

    `include "obj_tb_model.svh"

    obj_top obj_top_inst (
        .clk       (clk),
        .rst       (rst),
        .flip      (flip),
        .vrender   (vrender),
        .start     (start),
        .tbl_we    (tbl_we),
        .tbl_addr  (tbl_addr),
        .tbl_wdata (tbl_wdata),
        .gfx_addr  (gfx_addr),
        .gfx_data  (gfx_data),
        .busy      (busy),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ROM data one cycle after the address
    always @(posedge clk) begin
        gfx_data <= $isunknown(gfx_addr) ? 64'd0 : rom_row(gfx_addr);
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the scan never finished within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    function automatic logic [15:0] rnd16();
        return 16'($random(seed));
    endfunction

    task automatic put_entry(input int idx, input logic [8:0] x, input logic [8:0] y,
                             input logic [15:0] code, input logic [15:0] attr);
        tbl_mem[4*idx]     = {7'd0, x};
        tbl_mem[4*idx + 1] = {7'd0, y};
        tbl_mem[4*idx + 2] = code;
        tbl_mem[4*idx + 3] = attr;
    endtask

    // d = 256 lies past the tallest object
    task automatic fill_misses(input logic [8:0] vline);
        for (int i = 0; i < `OBJ_ENTRIES; i++) begin
            put_entry(i, 9'(rnd16()), vline + 9'd256, rnd16(), rnd16());
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < 4 * `OBJ_ENTRIES; i++) begin
            tbl_mem[i] = rnd16();
        end
    endtask

    task automatic write_table();
        for (int i = 0; i < 4 * `OBJ_ENTRIES; i++) begin
            @(posedge clk);
            tbl_we    <= 1'b1;
            tbl_addr  <= 10'(i);
            tbl_wdata <= tbl_mem[i];
        end
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    // pipelined readout, entry a-1 visible at the negedge of step a
    task automatic read_line(input bit want_empty);
        logic [14:0] want;
        for (int a = 0; a <= `OBJ_LINE_W; a++) begin
            @(posedge clk);
            rd_en   <= (a < `OBJ_LINE_W);
            rd_addr <= 9'(a);
            @(negedge clk);
            if (a > 0) begin
                want = want_empty ? 15'd0 : exp_line[a-1];
                checks++;
                assert (rd_data === want) else begin
                    $display("[ERROR] %0t rd_data[%0d] expected %h got %h",
                             $time, a - 1, want, rd_data);
                    test_errors++;
                end
            end
        end
    endtask

    task automatic run_test(input string name, input bit tflip, input logic [8:0] tvr);
        test_errors = 0;
        @(posedge clk);
        flip    <= tflip;
        vrender <= tvr;
        write_table();
        build_expected(tvr ^ {1'b0, {8{tflip}}});     // screen flip on low 8 bits
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        assert (busy === 1'b1) else begin
            $display("%0t busy did not rise after start", $time);
            test_errors++;
        end
        while (busy !== 1'b0) begin
            @(negedge clk);
        end
        read_line(1'b0);
        read_line(1'b1);       // first pass cleared it
        tests_run++;
        errors += test_errors;
        $display("test %0d %s: %0d errors", tests_run, name, test_errors);
    endtask

    initial begin
        logic [8:0]  vr;
        logic [15:0] attr;
        rst       = 1'b1;
        flip      = 1'b0;
        vrender   = '0;
        start     = 1'b0;
        tbl_we    = 1'b0;
        tbl_addr  = '0;
        tbl_wdata = '0;
        gfx_data  = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // lone 1x1 object, f[1] vflip f[0] hflip
        for (int f = 0; f < 4; f++) begin
            vr   = 9'($random(seed));
            fill_misses(vr);
            attr = {4'd0, 4'd0, 1'b0, f[1], f[0], 5'(rnd16())};
            put_entry(int'(rnd16() % 16'd256), 9'(rnd16()), vr - 9'(rnd16() % 16'd16),
                      rnd16(), attr);
            run_test($sformatf("single object flips %0d", f), 1'b0, vr);
        end

        // 2x2 pair, pal 3 on top, pal 20 flipped and shifted 8 px
        vr = 9'($random(seed));
        fill_misses(vr);
        put_entry(3, 9'd200, vr - 9'd5, 16'h0100, 16'h1103);
        put_entry(7, 9'd208, vr - 9'd5, 16'h0200, 16'h1174);
        run_test("overlap", 1'b0, vr);

        for (int t = 0; t < 2; t++) begin
            vr = 9'($random(seed));
            fill_random();
            put_entry(10, 9'd500, vr - 9'd3, rnd16(), {4'd0, 4'd3, 8'(rnd16())});  // wraps
            run_test($sformatf("random table %0d", t), 1'b0, vr);
        end

        vr = 9'($random(seed));
        fill_random();
        put_entry(20, 9'd505, (vr ^ 9'h0ff) - 9'd2, rnd16(), {4'd1, 4'd2, 8'(rnd16())});
        run_test("screen flip", 1'b1, vr);

        // one line above, one exactly below a 3-row object
        vr = 9'($random(seed));
        fill_misses(vr);
        put_entry(0, 9'd100, vr + 9'd1, rnd16(), 16'h0000);
        put_entry(1, 9'd120, vr - 9'd48, rnd16(), 16'h2300);
        run_test("objects off the line", 1'b0, vr);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: design/obj_top.sv
// ######################################################################
// sprite line scanner top level
// load the table and start only while busy is low
// rd_data = opaque[14] pal[13:9] zero[8:4] pixel[3:0]
// ######################################################################
`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flip,
    input  logic [8:0]             vrender,
    input  logic                   start,
    input  logic                   tbl_we,
    input  logic [9:0]             tbl_addr,
    input  logic [15:0]            tbl_wdata,
    output logic [`OBJ_GFX_AW-1:0] gfx_addr,
    input  logic [63:0]            gfx_data,
    output logic                   busy,
    input  logic                   rd_en,
    input  logic [8:0]             rd_addr,
    output logic [14:0]            rd_data
);

    logic [9:0]  frame_addr;
    logic [15:0] frame_data;

    draw_if draw_bus ();
    tile_if tile_bus [`OBJ_DRAWERS] ();
    pix_if  pix_bus  [`OBJ_DRAWERS] ();

    obj_frame_ram frame_ram_inst (
        .clk   (clk),
        .we    (tbl_we),
        .waddr (tbl_addr),
        .wdata (tbl_wdata),
        .raddr (frame_addr),
        .rdata (frame_data)
    );

    obj_line_table line_table_inst (
        .clk        (clk),
        .rst        (rst),
        .flip       (flip),
        .vrender    (vrender),
        .start      (start),
        .frame_addr (frame_addr),
        .frame_data (frame_data),
        .draw       (draw_bus)
    );

    obj_draw_dispatch draw_dispatch_inst (
        .clk      (clk),
        .rst      (rst),
        .draw     (draw_bus),
        .tiles    (tile_bus),
        .gfx_addr (gfx_addr),
        .gfx_data (gfx_data),
        .busy     (busy)
    );

    for (genvar i = 0; i < `OBJ_DRAWERS; i++) begin : g_draw
        obj_tile_draw tile_draw_inst (
            .clk  (clk),
            .rst  (rst),
            .tile (tile_bus[i]),
            .pix  (pix_bus[i])
        );
    end

    obj_line_buf line_buf_inst (
        .clk     (clk),
        .rst     (rst),
        .pix     (pix_bus),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: design/obj_line_buf.sv
// ######################################################################
// line buffer with a round-robin write port for the drawers
// lower prio wins on overlap, an empty entry takes any write
// a read returns the entry one cycle later and empties it
// ######################################################################
`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_line_buf (
    input  logic               clk,
    input  logic               rst,
    pix_if.sink                pix [`OBJ_DRAWERS],
    input  logic               rd_en,
    input  logic [8:0]         rd_addr,
    output obj_pkg::line_pix_t rd_data
);
    import obj_pkg::*;

    localparam int N  = `OBJ_DRAWERS;
    localparam int GW = $clog2(N);

    logic [N-1:0]  vld;
    logic [N-1:0]  gnt;
    logic [8:0]    x_a    [N];
    logic [8:0]    col_a  [N];
    logic [7:0]    prio_a [N];
    logic [GW-1:0] ptr;        // last granted drawer
    logic [GW-1:0] gidx;
    logic          found;
    logic          wr;

    logic [`OBJ_LINE_W-1:0] opq;                    // opaque flags
    logic [8:0]             col_mem  [`OBJ_LINE_W];
    logic [7:0]             prio_mem [`OBJ_LINE_W];

    for (genvar i = 0; i < N; i++) begin : g_src
        assign vld[i]       = pix[i].valid;
        assign x_a[i]       = pix[i].x;
        assign col_a[i]     = pix[i].color;
        assign prio_a[i]    = pix[i].prio;
        assign pix[i].grant = gnt[i];
    end

    // search starts one past the last winner
    always_comb begin
        int j;
        gidx  = ptr;
        found = 1'b0;
        for (int k = 1; k <= N; k++) begin
            j = (int'(ptr) + k) % N;
            if (!found && vld[j]) begin
                found = 1'b1;
                gidx  = GW'(j);
            end
        end
        gnt = found ? (N'(1) << gidx) : '0;
    end

    assign wr = found && (!opq[x_a[gidx]] || prio_a[gidx] < prio_mem[x_a[gidx]]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opq <= '0;
            ptr <= '0;
        end else begin
            if (found) ptr <= gidx;
            if (rd_en) opq[rd_addr] <= 1'b0;   // read clears
            if (wr)    opq[x_a[gidx]] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            col_mem[x_a[gidx]]  <= col_a[gidx];
            prio_mem[x_a[gidx]] <= prio_a[gidx];
        end
        if (rd_en) begin
            if (opq[rd_addr]) begin
                rd_data <= '{opaque: 1'b1, pal: col_mem[rd_addr][8:4], unused: 5'd0,
                             pix: col_mem[rd_addr][3:0]};
            end else begin
                rd_data <= '0;         // empty entry
            end
        end
    end

endmodule

// File: design/obj_tile_draw.sv
// ######################################################################
// turns one 16-pixel tile row into line buffer writes
// pixel value 15 is transparent and skipped without a write
// ######################################################################
`timescale 1ns/1ps

module obj_tile_draw (
    input  logic clk,
    input  logic rst,
    tile_if.draw tile,
    pix_if.src   pix
);
    import obj_pkg::*;

    draw_req_t   req_q;
    logic [63:0] row_q;
    logic        active;
    logic [3:0]  cnt;       // screen column within the tile
    logic [3:0]  col;       // nibble index in the row
    logic [3:0]  nib;
    logic        opaque;

    assign col    = req_q.hflip ? ~cnt : cnt;     // reversed order under hflip
    assign nib    = row_q[{col, 2'b00} +: 4];
    assign opaque = (nib != 4'hf);

    assign tile.free = !active;
    assign pix.valid = active && opaque;
    assign pix.x     = req_q.hpos + {5'd0, cnt};  // wraps at 512
    assign pix.color = {req_q.pal, nib};
    assign pix.prio  = req_q.prio;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (tile.load) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (active && (!opaque || pix.grant)) begin
            cnt <= cnt + 4'd1;              // hold until granted
            if (cnt == 4'd15) begin
                active <= 1'b0;             // free again next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile.load) begin
            req_q <= tile.req;
            row_q <= tile.row;
        end
    end

endmodule

// File: design/obj_draw_dispatch.sv
// ######################################################################
// fetches one tile row from the graphics ROM per request
// gfx_data must be valid one cycle after gfx_addr and held with it
// the lowest numbered free drawer takes the row
// ######################################################################
`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_draw_dispatch (
    input  logic                   clk,
    input  logic                   rst,
    draw_if.disp                   draw,
    tile_if.disp                   tiles [`OBJ_DRAWERS],
    output logic [`OBJ_GFX_AW-1:0] gfx_addr,
    input  logic [63:0]            gfx_data,
    output logic                   busy
);
    import obj_pkg::*;

    localparam int N  = `OBJ_DRAWERS;
    localparam int SW = $clog2(N);

    typedef enum logic [1:0] {D_IDLE, D_FETCH, D_LOAD} disp_state_e;

    disp_state_e   st;
    draw_req_t     req_q;
    logic [N-1:0]  free;
    logic [SW-1:0] sel;
    logic          any_free;

    assign draw.idle = (st == D_IDLE);
    assign busy      = draw.scan_busy || (st != D_IDLE) || !(&free);

    // lowest free drawer wins
    always_comb begin
        sel      = '0;
        any_free = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            if (free[i]) begin
                sel      = SW'(i);
                any_free = 1'b1;
            end
        end
    end

    for (genvar i = 0; i < N; i++) begin : g_tile
        assign free[i]       = tiles[i].free;
        assign tiles[i].load = (st == D_LOAD) && any_free && (sel == SW'(i));
        assign tiles[i].req  = req_q;
        assign tiles[i].row  = gfx_data;   // drawer latches it on load
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st <= D_IDLE;
        end else begin
            case (st)
                D_IDLE:  if (draw.start) st <= D_FETCH;
                D_FETCH: st <= D_LOAD;                   // ROM data due next cycle
                D_LOAD:  if (any_free) st <= D_IDLE;     // stall until a drawer frees up
                default: st <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (draw.start && st == D_IDLE) begin
            req_q    <= draw.req;
            gfx_addr <= {draw.req.code_mn, draw.req.vsub};
        end
    end

endmodule

// File: design/obj_line_table.sv
// ######################################################################
// walks the object table from the last entry down to entry 0
// each covering object is split into tile_n+1 draw requests
// table must not be written while scan_busy is high
// ######################################################################
`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_line_table (
    input  logic        clk,
    input  logic        rst,
    input  logic        flip,
    input  logic [8:0]  vrender,
    input  logic        start,
    output logic [9:0]  frame_addr,
    input  logic [15:0] frame_data,
    draw_if.scan        draw
);
    import obj_pkg::*;

    localparam int IDX_W = $clog2(`OBJ_ENTRIES);

    scan_state_e      st;
    logic [IDX_W-1:0] idx;          // current table entry
    logic [8:0]       vline;        // line under test, flip applied
    logic [8:0]       obj_x;
    logic [8:0]       obj_y;
    logic [15:0]      obj_code;
    logic [15:0]      obj_attr;
    logic [3:0]       n;            // tile column count
    logic [3:0]       npos;         // tile column position on screen
    logic [3:0]       vsub;
    logic             inzone;
    logic [15:0]      code_mn;
    logic             hflip;
    logic [3:0]       tile_n;

    assign hflip  = obj_attr[5];
    assign tile_n = obj_attr[11:8];

    obj_tile_match tile_match_inst (
        .clk      (clk),
        .obj_code (obj_code),
        .tile_m   (obj_attr[15:12]),
        .tile_n   (tile_n),
        .n        (n),
        .vflip    (obj_attr[6]),
        .vline    (vline),
        .obj_y    (obj_y),
        .vsub     (vsub),
        .inzone   (inzone),
        .code_mn  (code_mn)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st             <= IDLE;
            idx            <= '0;
            frame_addr     <= '0;
            n              <= '0;
            npos           <= '0;
            draw.start     <= 1'b0;
            draw.scan_busy <= 1'b0;
        end else begin
            draw.start <= 1'b0;    // strobe
            case (st)
                IDLE: if (start) begin
                    idx            <= IDX_W'(`OBJ_ENTRIES - 1);
                    frame_addr     <= {IDX_W'(`OBJ_ENTRIES - 1), 2'd0};
                    draw.scan_busy <= 1'b1;
                    st             <= ADDR;
                end
                ADDR: begin
                    frame_addr <= {idx, 2'd1};
                    st         <= RD_X;
                end
                RD_X: begin
                    frame_addr <= {idx, 2'd2};
                    st         <= RD_Y;
                end
                RD_Y: begin
                    frame_addr <= {idx, 2'd3};
                    st         <= RD_CODE;
                end
                RD_CODE: st <= RD_ATTR;
                RD_ATTR: begin
                    n    <= 4'd0;
                    // flipped objects start from the rightmost column
                    npos <= frame_data[5] ? frame_data[11:8] : 4'd0;
                    st   <= MATCH;
                end
                MATCH: st <= ISSUE;
                ISSUE: begin
                    // idle stays low 2 cycles after start, covering the match latency
                    if (!inzone) begin
                        st <= NEXT_TILE;
                    end else if (draw.idle) begin
                        draw.start <= 1'b1;
                        st         <= NEXT_TILE;
                    end
                end
                NEXT_TILE: begin
                    if (!inzone || n == tile_n) begin
                        if (idx == '0) begin     // entry 0 was the last one
                            draw.scan_busy <= 1'b0;
                            st             <= IDLE;
                        end else begin
                            idx        <= idx - 1'b1;
                            frame_addr <= {idx - 1'b1, 2'd0};
                            st         <= ADDR;
                        end
                    end else begin
                        n    <= n + 4'd1;
                        npos <= hflip ? npos - 4'd1 : npos + 4'd1;
                        st   <= ISSUE;
                    end
                end
                default: st <= IDLE;
            endcase
        end
    end

    // entry words and the outgoing request
    always_ff @(posedge clk) begin
        if (st == IDLE && start) vline <= vrender ^ {1'b0, {8{flip}}};
        if (st == RD_X)    obj_x    <= frame_data[8:0];
        if (st == RD_Y)    obj_y    <= frame_data[8:0];
        if (st == RD_CODE) obj_code <= frame_data;
        if (st == RD_ATTR) obj_attr <= frame_data;
        if (st == ISSUE && inzone && draw.idle) begin
            draw.req.code_mn <= code_mn;
            draw.req.vsub    <= vsub;
            draw.req.pal     <= obj_attr[4:0];
            draw.req.hflip   <= hflip;
            draw.req.hpos    <= obj_x + {1'b0, npos, 4'd0};    // wraps at 512
            draw.req.prio    <= idx;
        end
    end

endmodule

// File: design/obj_tile_match.sv
// ######################################################################
// line hit test and tile row select for one object
// all outputs registered, one cycle after the inputs
// ######################################################################
`timescale 1ns/1ps

module obj_tile_match (
    input  logic        clk,
    input  logic [15:0] obj_code,
    input  logic [3:0]  tile_m,     // rows minus one
    input  logic [3:0]  tile_n,     // columns minus one
    input  logic [3:0]  n,          // column being expanded
    input  logic        vflip,
    input  logic [8:0]  vline,
    input  logic [8:0]  obj_y,
    output logic [3:0]  vsub,
    output logic        inzone,
    output logic [15:0] code_mn
);

    logic [8:0] d;      // line offset inside the object
    logic [3:0] r;      // tile row

    assign d = vline - obj_y;                      // mod 512
    assign r = vflip ? tile_m - d[7:4] : d[7:4];

    always_ff @(posedge clk) begin
        // d < 16*(tile_m+1)
        inzone  <= (d[8:4] <= {1'b0, tile_m});
        vsub    <= vflip ? ~d[3:0] : d[3:0];       // 15-d under vflip
        code_mn <= obj_code + {12'd0, n} + {8'd0, r, 4'd0};
    end

endmodule

// File: design/obj_frame_ram.sv
// ######################################################################
// object table RAM, one write port and one synchronous read port
// read data one cycle after raddr, contents undefined until written
// ######################################################################
`timescale 1ns/1ps
`include "obj_cfg.svh"

module obj_frame_ram (
    input  logic        clk,
    input  logic        we,
    input  logic [9:0]  waddr,
    input  logic [15:0] wdata,
    input  logic [9:0]  raddr,
    output logic [15:0] rdata
);

    logic [15:0] mem [4*`OBJ_ENTRIES];     // four words per entry

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;   // table load from the top ports
        end
        rdata <= mem[raddr];       // scanner side
    end

endmodule

// File: design/obj_if.sv
// ######################################################################
// internal links of the sprite scanner
// draw_if and tile_if use one-cycle strobes, pix_if holds until grant
// ######################################################################
`timescale 1ns/1ps

// scanner to dispatcher
interface draw_if;
    import obj_pkg::*;
    logic      start;       // strobe, only while idle
    draw_req_t req;
    logic      scan_busy;
    logic      idle;

    modport scan (output start, req, scan_busy, input idle);
    modport disp (input start, req, scan_busy, output idle);
endinterface

// dispatcher to one drawer
interface tile_if;
    import obj_pkg::*;
    logic        load;      // strobe, only while free
    draw_req_t   req;
    logic [63:0] row;       // nibble i is pixel i
    logic        free;

    modport disp (output load, req, row, input free);
    modport draw (input load, req, row, output free);
endinterface

// one drawer to the line buffer
interface pix_if;
    logic       valid;
    logic [8:0] x;
    logic [8:0] color;      // pal & nibble
    logic [7:0] prio;
    logic       grant;

    modport src  (output valid, x, color, prio, input grant);
    modport sink (input valid, x, color, prio, output grant);
endinterface

// File: design/obj_pkg.sv
// ######################################################################
// shared types for the sprite line scanner
// table entry at index*4: +0 x[8:0], +1 y[8:0], +2 tile code,
// +3 attr = tile_m[15:12] tile_n[11:8] vflip[6] hflip[5] pal[4:0]
// ######################################################################
package obj_pkg;

    // table scanner FSM
    typedef enum logic [3:0] {
        IDLE,
        ADDR,       // address of x word already on the RAM
        RD_X,
        RD_Y,
        RD_CODE,
        RD_ATTR,
        MATCH,      // tile match registers its result
        ISSUE,      // hold here until the dispatcher is idle
        NEXT_TILE
    } scan_state_e;

    // one 16-pixel tile row to draw
    typedef struct packed {
        logic [15:0] code_mn;   // tile code incl. row and column offset
        logic [3:0]  vsub;      // pixel row inside the tile
        logic [4:0]  pal;
        logic        hflip;
        logic [8:0]  hpos;      // x of leftmost pixel
        logic [7:0]  prio;      // table index, lower on top
    } draw_req_t;

    // line buffer readout word
    typedef struct packed {
        logic       opaque;
        logic [4:0] pal;
        logic [4:0] unused;     // always zero
        logic [3:0] pix;
    } line_pix_t;

endpackage

// File: design/obj_cfg.svh
// ######################################################################
// sizes for the sprite line scanner
// gfx address is code_mn (16) then vsub (4), so OBJ_GFX_AW must be 20
// x is 9 bits wide everywhere, so OBJ_LINE_W is fixed at 512
// ######################################################################
`ifndef OBJ_CFG_SVH
`define OBJ_CFG_SVH

// identical tile drawers fed by the dispatcher
`define OBJ_DRAWERS 4

// object table entries, four 16-bit words each
`define OBJ_ENTRIES 256

// line buffer pixels
`define OBJ_LINE_W 512

// graphics ROM address bits
`define OBJ_GFX_AW 20

`endif
